// File: common/sys_pkg.sv
package sys_pkg;

  localparam int dword_width_c    = 64;
  localparam int vaddr_width_c    = 39;
  localparam int ptag_width_c     = 28;
  localparam int csr_addr_width_c = 12;

  // machine csr numbers
  localparam logic [csr_addr_width_c-1:0] csr_mstatus_c  = 12'h300;
  localparam logic [csr_addr_width_c-1:0] csr_mtvec_c    = 12'h305;
  localparam logic [csr_addr_width_c-1:0] csr_mscratch_c = 12'h340;
  localparam logic [csr_addr_width_c-1:0] csr_mepc_c     = 12'h341;
  localparam logic [csr_addr_width_c-1:0] csr_mcause_c   = 12'h342;
  localparam logic [csr_addr_width_c-1:0] csr_mtval_c    = 12'h343;
  localparam logic [csr_addr_width_c-1:0] csr_satp_c     = 12'h180;

  localparam logic [3:0] cause_illegal_c = 4'd2;
  localparam logic [3:0] cause_ecall_u_c = 4'd8;
  localparam logic [3:0] cause_ecall_s_c = 4'd9;
  localparam logic [3:0] cause_ecall_m_c = 4'd11;
  localparam logic [3:0] cause_ipf_c     = 4'd12;
  localparam logic [3:0] cause_lpf_c     = 4'd13;
  localparam logic [3:0] cause_spf_c     = 4'd15;

  // mpp occupies two bits starting here
  localparam int mstatus_mpp_lsb_c = 11;
  localparam int mstatus_sum_bit_c = 18;
  localparam int mstatus_mxr_bit_c = 19;
  localparam int satp_mode_bit_c   = 63;

  typedef enum logic [2:0] {
    e_csrrw,
    e_csrrs,
    e_csrrc,
    e_csrrwi,
    e_csrrsi,
    e_csrrci,
    e_ecall,
    e_mret
  } sys_op_e;

  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } priv_e;

  typedef struct packed {
    sys_op_e                     op;
    logic [csr_addr_width_c-1:0] addr;
    logic [dword_width_c-1:0]    data;
  } sys_cmd_s;

  typedef struct packed {
    logic itlb_miss;
    logic dtlb_miss;
    logic illegal;
    logic instr_page_fault;
    logic load_page_fault;
    logic store_page_fault;
  } sys_exc_s;

  typedef struct packed {
    logic                     instr_miss_v;
    logic                     load_miss_v;
    logic                     store_miss_v;
    logic [vaddr_width_c-1:0] pc;
    logic [vaddr_width_c-1:0] vaddr;
  } ptw_miss_s;

  typedef struct packed {
    logic                     instr_page_fault_v;
    logic                     load_page_fault_v;
    logic                     store_page_fault_v;
    logic [vaddr_width_c-1:0] pc;
    logic [vaddr_width_c-1:0] vaddr;
  } ptw_fill_s;

  typedef struct packed {
    logic                     v;
    logic                     exception;
    logic                     rollback;
    logic                     eret;
    logic [vaddr_width_c-1:0] npc;
    logic [3:0]               cause;
  } trap_pkt_s;

endpackage

// File: dv/sys_pipe_asserts.sv
`timescale 1ns/1ps

module sys_pipe_asserts
  import sys_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input trap_pkt_s trap_i,
  input ptw_miss_s miss_i
);

  // replay and trap entry exclude each other
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(trap_i.exception && trap_i.rollback))
    else $error("trap exception and rollback asserted together");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({miss_i.instr_miss_v, miss_i.load_miss_v, miss_i.store_miss_v}))
    else $error("more than one walker miss valid asserted");

  assert property (@(posedge clk_i) !rst_n_i |=> !trap_i.v)
    else $error("trap valid asserted in the cycle after reset");

endmodule

bind sys_pipe sys_pipe_asserts asserts_i (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .trap_i  (trap_o),
  .miss_i  (ptw_miss_o)
);

// File: dv/sys_pipe_tb.sv
`timescale 1ns/1ps

module sys_pipe_tb
  import sys_pkg::*;
();

  logic                        clk_i = 1'b0;
  logic                        rst_n_i;
  logic                        op_v_i;
  sys_op_e                     op_i;
  logic [csr_addr_width_c-1:0] csr_addr_i;
  logic [dword_width_c-1:0]    rs1_i;
  logic [dword_width_c-1:0]    imm_i;
  logic                        is_store_i;
  logic                        kill_ex1_i;
  logic                        kill_ex2_i;
  logic                        kill_ex3_i;
  sys_exc_s                    exc_i;
  logic [vaddr_width_c-1:0]    exc_pc_i;
  logic [vaddr_width_c-1:0]    exc_vaddr_i;
  ptw_fill_s                   fill_i;
  ptw_miss_s                   ptw_miss_o;
  logic [dword_width_c-1:0]    data_o;
  trap_pkt_s                   trap_o;
  priv_e                       priv_mode_o;
  logic [ptag_width_c-1:0]     satp_ppn_o;
  logic                        translation_en_o;
  logic                        mstatus_sum_o;
  logic                        mstatus_mxr_o;

  // expected machine state
  logic [dword_width_c-1:0]    model_csr [logic [csr_addr_width_c-1:0]];
  priv_e                       model_priv;
  logic [dword_width_c-1:0]    got_data;
  trap_pkt_s                   got_trap;
  ptw_miss_s                   got_miss;
  int                          errors;
  int                          checks;
  int                          tests;

  sys_pipe dut_i (.*);

  initial
  begin
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [dword_width_c-1:0] rand_dword();
    return {$urandom(), $urandom()};
  endfunction

  function automatic logic [vaddr_width_c-1:0] rand_vaddr();
    logic [dword_width_c-1:0] r;
    r = rand_dword();
    return r[vaddr_width_c-1:0];
  endfunction

  function automatic logic [dword_width_c-1:0] model_read(
    input logic [csr_addr_width_c-1:0] addr
  );
    return model_csr.exists(addr) ? model_csr[addr] : '0;
  endfunction

  function automatic logic [3:0] ecall_cause(input priv_e p);
    case (p)
      e_priv_u: return cause_ecall_u_c;
      e_priv_s: return cause_ecall_s_c;
      default:  return cause_ecall_m_c;
    endcase
  endfunction

  function automatic trap_pkt_s exc_trap(input logic [3:0] cause);
    trap_pkt_s                t;
    logic [dword_width_c-1:0] tvec;
    tvec        = model_read(csr_mtvec_c);
    t           = '0;
    t.v         = 1'b1;
    t.exception = 1'b1;
    t.npc       = tvec[vaddr_width_c-1:0];
    t.cause     = cause;
    return t;
  endfunction

  task automatic check_data(input string name, input logic [dword_width_c-1:0] got,
                            input logic [dword_width_c-1:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // a packet with its valid low is only checked for the valid
  task automatic check_trap(input string name, input trap_pkt_s got, input trap_pkt_s exp);
    checks++;
    if ((exp.v && got !== exp) || (!exp.v && got.v !== 1'b0))
    begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_miss(input string name, input ptw_miss_s got, input ptw_miss_s exp);
    logic any_v;
    any_v = exp.instr_miss_v | exp.load_miss_v | exp.store_miss_v;
    checks++;
    if ((any_v && got !== exp) || (!any_v && (got.instr_miss_v | got.load_miss_v
        | got.store_miss_v) !== 1'b0))
    begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_priv(input string name, input priv_e got, input priv_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %s done with %0d errors", name, errors - errs_before);
  endtask

  // one command from stage one to stage three with results captured there
  task automatic run_cmd(
    input sys_op_e                     op,
    input logic [csr_addr_width_c-1:0] addr,
    input logic [dword_width_c-1:0]    rs1,
    input logic [dword_width_c-1:0]    imm,
    input logic                        is_store = 1'b0,
    input logic [2:0]                  kills = 3'b000,
    input sys_exc_s                    exc = '0,
    input logic [vaddr_width_c-1:0]    pc = '0,
    input logic [vaddr_width_c-1:0]    vaddr = '0,
    input ptw_fill_s                   fill = '0
  );
    int stage;
    int cycles;
    @(negedge clk_i);
    op_v_i     = 1'b1;
    op_i       = op;
    csr_addr_i = addr;
    rs1_i      = rs1;
    imm_i      = imm;
    is_store_i = is_store;
    kill_ex1_i = kills[0];
    stage      = 1;
    cycles     = 0;
    while (stage != 3 && cycles < 4)
    begin
      @(negedge clk_i);
      stage++;
      cycles++;
      op_v_i     = 1'b0;
      is_store_i = 1'b0;
      kill_ex1_i = 1'b0;
      kill_ex2_i = (stage == 2) ? kills[1] : 1'b0;
    end
    if (stage != 3)
    begin
      $display("timeout while waiting for the command to reach stage three");
      $display("Result: FAILED");
      $finish;
    end
    else
    begin
      kill_ex3_i  = kills[2];
      exc_i       = exc;
      exc_pc_i    = pc;
      exc_vaddr_i = vaddr;
      fill_i      = fill;
      #5;
      got_data = data_o;
      got_trap = trap_o;
      got_miss = ptw_miss_o;
      @(negedge clk_i);
      kill_ex3_i  = 1'b0;
      exc_i       = '0;
      exc_pc_i    = '0;
      exc_vaddr_i = '0;
      fill_i      = '0;
    end
  endtask

  task automatic csr_access(input sys_op_e op, input logic [csr_addr_width_c-1:0] addr,
                            input logic [dword_width_c-1:0] rs1,
                            input logic [dword_width_c-1:0] imm);
    logic [dword_width_c-1:0] old_v;
    logic [dword_width_c-1:0] operand;
    logic [dword_width_c-1:0] new_v;
    old_v   = model_read(addr);
    operand = (op inside {e_csrrwi, e_csrrsi, e_csrrci}) ? imm : rs1;
    case (op)
      e_csrrs, e_csrrsi: new_v = old_v | operand;
      e_csrrc, e_csrrci: new_v = old_v & ~operand;
      default:           new_v = operand;
    endcase
    run_cmd(op, addr, rs1, imm);
    check_data("data_o", got_data, old_v);
    check_trap("trap_o", got_trap, '0);
    if (model_csr.exists(addr))
      model_csr[addr] = new_v;
  endtask

  task automatic read_csr(input logic [csr_addr_width_c-1:0] addr);
    csr_access(e_csrrs, addr, '0, '0);
  endtask

  task automatic do_ecall(input logic [vaddr_width_c-1:0] pc);
    trap_pkt_s exp;
    exp = exc_trap(ecall_cause(model_priv));
    run_cmd(e_ecall, csr_mscratch_c, '0, '0, 1'b0, 3'b000, '0, pc);
    check_trap("trap_o", got_trap, exp);
    model_trap(exp.cause, pc, '0);
    check_priv("priv_mode_o", priv_mode_o, model_priv);
  endtask

  task automatic model_trap(input logic [3:0] cause, input logic [vaddr_width_c-1:0] pc,
                            input logic [vaddr_width_c-1:0] tval);
    logic [dword_width_c-1:0] ms;
    ms = model_csr[csr_mstatus_c];
    ms[mstatus_mpp_lsb_c +: 2] = model_priv;
    model_csr[csr_mstatus_c] = ms;
    model_csr[csr_mepc_c]    = dword_width_c'(pc);
    model_csr[csr_mcause_c]  = dword_width_c'(cause);
    model_csr[csr_mtval_c]   = dword_width_c'(tval);
    model_priv = e_priv_m;
  endtask

  task automatic csr_access_test();
    sys_op_e                     ops [6];
    logic [csr_addr_width_c-1:0] addrs [2];
    int                          errs0;
    errs0 = errors;
    ops   = '{e_csrrw, e_csrrs, e_csrrc, e_csrrwi, e_csrrsi, e_csrrci};
    addrs = '{csr_mscratch_c, csr_mtvec_c};
    foreach (addrs[a])
    begin
      foreach (ops[o])
        csr_access(ops[o], addrs[a], rand_dword(), rand_dword());
      read_csr(addrs[a]);
    end
    // unmapped address
    csr_access(e_csrrw, 12'h7c0, rand_dword(), '0);
    read_csr(12'h7c0);
    report_test("csr_access", errs0);
  endtask

  task automatic kill_test();
    int errs0;
    errs0 = errors;
    for (int s = 0; s < 3; s++)
    begin
      run_cmd(e_csrrw, csr_mscratch_c, rand_dword(), '0, 1'b0, 3'b001 << s);
      read_csr(csr_mscratch_c);
      run_cmd(e_ecall, csr_mscratch_c, '0, '0, 1'b0, 3'b001 << s, '0, rand_vaddr());
      check_trap("trap_o", got_trap, '0);
    end
    read_csr(csr_mepc_c);
    read_csr(csr_mcause_c);
    report_test("kill", errs0);
  endtask

  task automatic ecall_test();
    int errs0;
    errs0 = errors;
    csr_access(e_csrrw, csr_mtvec_c, dword_width_c'(rand_vaddr()), '0);
    do_ecall(rand_vaddr());
    read_csr(csr_mcause_c);
    read_csr(csr_mepc_c);
    read_csr(csr_mstatus_c);
    report_test("ecall", errs0);
  endtask

  task automatic mret_test();
    logic [dword_width_c-1:0] ms;
    logic [dword_width_c-1:0] mepc_v;
    logic [ptag_width_c-1:0]  ppn;
    trap_pkt_s                exp;
    int                       errs0;
    errs0 = errors;
    ms = model_read(csr_mstatus_c);
    ms[mstatus_mpp_lsb_c +: 2] = e_priv_s;
    ms[mstatus_sum_bit_c]      = 1'b1;
    csr_access(e_csrrw, csr_mstatus_c, ms, '0);
    check_data("mstatus_sum_o", dword_width_c'(mstatus_sum_o), 64'd1);
    check_data("mstatus_mxr_o", dword_width_c'(mstatus_mxr_o), 64'd0);
    ppn = ptag_width_c'(rand_vaddr());
    csr_access(e_csrrw, csr_satp_c, {1'b1, 35'd0, ppn}, '0);
    mepc_v   = model_read(csr_mepc_c);
    exp      = '0;
    exp.v    = 1'b1;
    exp.eret = 1'b1;
    exp.npc  = mepc_v[vaddr_width_c-1:0];
    run_cmd(e_mret, csr_mstatus_c, '0, '0);
    check_trap("trap_o", got_trap, exp);
    model_priv = priv_e'(ms[mstatus_mpp_lsb_c +: 2]);
    ms[mstatus_mpp_lsb_c +: 2] = e_priv_u;
    model_csr[csr_mstatus_c] = ms;
    check_priv("priv_mode_o", priv_mode_o, model_priv);
    check_data("translation_en_o", dword_width_c'(translation_en_o), 64'd1);
    check_data("satp_ppn_o", dword_width_c'(satp_ppn_o), dword_width_c'(ppn));
    read_csr(csr_mstatus_c);
    // ecall from supervisor drops translation again
    do_ecall(rand_vaddr());
    check_data("translation_en_o", dword_width_c'(translation_en_o), 64'd0);
    read_csr(csr_mcause_c);
    read_csr(csr_mstatus_c);
    csr_access(e_csrrsi, csr_mstatus_c, '0, 64'd1 << mstatus_mxr_bit_c);
    check_data("mstatus_mxr_o", dword_width_c'(mstatus_mxr_o), 64'd1);
    report_test("mret", errs0);
  endtask

  task automatic tlb_miss_test();
    sys_exc_s                 exc;
    ptw_miss_s                exp_miss;
    trap_pkt_s                exp_trap;
    logic [vaddr_width_c-1:0] pc;
    logic [vaddr_width_c-1:0] va;
    int                       errs0;
    errs0 = errors;
    for (int i = 0; i < 4; i++)
    begin
      exc           = '0;
      exc.itlb_miss = (i == 0);
      exc.dtlb_miss = (i != 0);
      pc            = rand_vaddr();
      va            = rand_vaddr();
      exp_miss      = '0;
      exp_trap      = '0;
      // case 3 is killed in stage three
      if (i < 3)
      begin
        exp_miss.instr_miss_v = (i == 0);
        exp_miss.load_miss_v  = (i == 1);
        exp_miss.store_miss_v = (i == 2);
        exp_miss.pc           = pc;
        exp_miss.vaddr        = (i == 0) ? pc : va;
        exp_trap.v            = 1'b1;
        exp_trap.rollback     = 1'b1;
      end
      run_cmd(e_csrrw, csr_mscratch_c, rand_dword(), '0, (i >= 2), {i == 3, 2'b00},
              exc, pc, va);
      check_miss("ptw_miss_o", got_miss, exp_miss);
      check_trap("trap_o", got_trap, exp_trap);
    end
    read_csr(csr_mscratch_c);
    read_csr(csr_mepc_c);
    check_priv("priv_mode_o", priv_mode_o, model_priv);
    report_test("tlb_miss", errs0);
  endtask

  task automatic fill_fault_test();
    ptw_fill_s                fill;
    sys_exc_s                 exc;
    trap_pkt_s                exp;
    logic [3:0]               cause;
    logic [vaddr_width_c-1:0] pc;
    logic [vaddr_width_c-1:0] va;
    int                       errs0;
    errs0 = errors;
    // a pending dtlb miss loses to the fill fault
    exc           = '0;
    exc.dtlb_miss = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      pc                      = rand_vaddr();
      va                      = rand_vaddr();
      fill                    = '0;
      fill.instr_page_fault_v = (i == 0);
      fill.load_page_fault_v  = (i == 1);
      fill.store_page_fault_v = (i >= 2);
      fill.pc                 = pc;
      fill.vaddr              = va;
      cause = (i == 0) ? cause_ipf_c : (i == 1) ? cause_lpf_c : cause_spf_c;
      exp   = exc_trap(cause);
      run_cmd(e_csrrw, csr_mscratch_c, rand_dword(), '0, 1'b0, {i == 3, 2'b00},
              exc, rand_vaddr(), rand_vaddr(), fill);
      check_trap("trap_o", got_trap, exp);
      check_miss("ptw_miss_o", got_miss, '0);
      model_trap(cause, pc, va);
      read_csr(csr_mtval_c);
      read_csr(csr_mcause_c);
      read_csr(csr_mepc_c);
    end
    read_csr(csr_mscratch_c);
    report_test("fill_fault", errs0);
  endtask

  initial
  begin
    logic [csr_addr_width_c-1:0] known [7];
    void'($urandom(59));
    rst_n_i     = 1'b0;
    op_v_i      = 1'b0;
    op_i        = e_csrrw;
    csr_addr_i  = '0;
    rs1_i       = '0;
    imm_i       = '0;
    is_store_i  = 1'b0;
    kill_ex1_i  = 1'b0;
    kill_ex2_i  = 1'b0;
    kill_ex3_i  = 1'b0;
    exc_i       = '0;
    exc_pc_i    = '0;
    exc_vaddr_i = '0;
    fill_i      = '0;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    known = '{csr_mstatus_c, csr_mtvec_c, csr_mepc_c, csr_mcause_c,
              csr_mtval_c, csr_mscratch_c, csr_satp_c};
    foreach (known[k])
      model_csr[known[k]] = '0;
    model_priv = e_priv_m;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_priv("priv_mode_o", priv_mode_o, e_priv_m);
    check_data("translation_en_o", dword_width_c'(translation_en_o), 64'd0);
    csr_access_test();
    kill_test();
    ecall_test();
    mret_test();
    tlb_miss_test();
    fill_fault_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: filelist.f
common/sys_pkg.sv
sys_pipe/sys_cmd_pipe.sv
sys_pipe/sys_fault_sel.sv
sys_pipe/sys_csr_file.sv
sys_pipe/sys_pipe.sv
dv/sys_pipe_asserts.sv
dv/sys_pipe_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sys_pipe_tb \
  -f filelist.f -Mdir obj_dir -o sys_pipe_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sys_pipe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0

// File: sys_pipe/sys_cmd_pipe.sv
`timescale 1ns/1ps

module sys_cmd_pipe
  import sys_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        op_v_i,
  input  sys_op_e                     op_i,
  input  logic [csr_addr_width_c-1:0] csr_addr_i,
  input  logic [dword_width_c-1:0]    rs1_i,
  input  logic [dword_width_c-1:0]    imm_i,
  input  logic                        kill_ex1_i,
  input  logic                        kill_ex2_i,
  input  logic                        kill_ex3_i,
  output sys_cmd_s                    cmd_o,
  output logic                        cmd_v_o
);

  sys_cmd_s cmd_ex1;
  sys_cmd_s cmd_ex2_r;
  sys_cmd_s cmd_ex3_r;
  logic     v_ex2_r;
  logic     v_ex3_r;
  logic     imm_op;

  assign imm_op = op_i inside {e_csrrwi, e_csrrsi, e_csrrci};

  always_comb
  begin
    cmd_ex1.op   = op_i;
    cmd_ex1.addr = csr_addr_i;
    cmd_ex1.data = imm_op ? imm_i : rs1_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      v_ex2_r <= 1'b0;
      v_ex3_r <= 1'b0;
    end
    else
    begin
      v_ex2_r <= op_v_i & ~kill_ex1_i;
      v_ex3_r <= v_ex2_r & ~kill_ex2_i;
    end
  end

  // payload shifts every cycle, the valids decide
  always_ff @(posedge clk_i)
  begin
    cmd_ex2_r <= cmd_ex1;
    cmd_ex3_r <= cmd_ex2_r;
  end

  assign cmd_o   = cmd_ex3_r;
  assign cmd_v_o = v_ex3_r & ~kill_ex3_i;

endmodule

// File: sys_pipe/sys_csr_file.sv
`timescale 1ns/1ps

module sys_csr_file
  import sys_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  sys_cmd_s                 cmd_i,
  input  logic                     cmd_v_i,
  input  sys_exc_s                 exc_i,
  input  logic [vaddr_width_c-1:0] exc_pc_i,
  input  logic [vaddr_width_c-1:0] exc_tval_i,
  output logic [dword_width_c-1:0] data_o,
  output trap_pkt_s                trap_o,
  output priv_e                    priv_mode_o,
  output logic [ptag_width_c-1:0]  satp_ppn_o,
  output logic                     translation_en_o,
  output logic                     mstatus_sum_o,
  output logic                     mstatus_mxr_o
);

  logic [dword_width_c-1:0] mstatus_r, mtvec_r, mepc_r, mcause_r;
  logic [dword_width_c-1:0] mtval_r, mscratch_r, satp_r;
  logic [dword_width_c-1:0] csr_rdata, csr_wdata;
  priv_e                    priv_r;
  logic                     csr_op, csr_we, ecall_v, mret_v;
  logic                     rollback_v, exc_v;
  logic [3:0]               cause, ecall_cause;

  assign csr_op  = cmd_v_i & (cmd_i.op inside {e_csrrw, e_csrrs, e_csrrc,
                                                e_csrrwi, e_csrrsi, e_csrrci});
  assign ecall_v = cmd_v_i & (cmd_i.op == e_ecall);

  always_comb
  begin
    case (cmd_i.addr)
      csr_mstatus_c:  csr_rdata = mstatus_r;
      csr_mtvec_c:    csr_rdata = mtvec_r;
      csr_mepc_c:     csr_rdata = mepc_r;
      csr_mcause_c:   csr_rdata = mcause_r;
      csr_mtval_c:    csr_rdata = mtval_r;
      csr_mscratch_c: csr_rdata = mscratch_r;
      csr_satp_c:     csr_rdata = satp_r;
      default:        csr_rdata = '0;
    endcase
  end

  always_comb
  begin
    case (cmd_i.op)
      e_csrrs, e_csrrsi: csr_wdata = csr_rdata | cmd_i.data;
      e_csrrc, e_csrrci: csr_wdata = csr_rdata & ~cmd_i.data;
      default:           csr_wdata = cmd_i.data;
    endcase
  end

  always_comb
  begin
    case (priv_r)
      e_priv_u: ecall_cause = cause_ecall_u_c;
      e_priv_s: ecall_cause = cause_ecall_s_c;
      default:  ecall_cause = cause_ecall_m_c;
    endcase
  end

  // highest priority first
  always_comb
  begin
    if (exc_i.instr_page_fault)
      cause = cause_ipf_c;
    else if (exc_i.illegal)
      cause = cause_illegal_c;
    else if (ecall_v)
      cause = ecall_cause;
    else if (exc_i.store_page_fault)
      cause = cause_spf_c;
    else if (exc_i.load_page_fault)
      cause = cause_lpf_c;
    else
      cause = '0;
  end

  // a tlb miss replays the access, so it masks everything else
  assign rollback_v = exc_i.itlb_miss | exc_i.dtlb_miss;
  assign exc_v      = ~rollback_v & (exc_i.instr_page_fault | exc_i.load_page_fault
                    | exc_i.store_page_fault | exc_i.illegal | ecall_v);
  assign mret_v     = ~rollback_v & ~exc_v & cmd_v_i & (cmd_i.op == e_mret);
  assign csr_we     = csr_op & ~rollback_v & ~exc_v;

  always_comb
  begin
    trap_o           = '0;
    trap_o.exception = exc_v;
    trap_o.rollback  = rollback_v;
    trap_o.eret      = mret_v;
    trap_o.v         = exc_v | rollback_v | mret_v;
    trap_o.cause     = exc_v ? cause : '0;
    if (exc_v)
      trap_o.npc = mtvec_r[vaddr_width_c-1:0];
    else if (mret_v)
      trap_o.npc = mepc_r[vaddr_width_c-1:0];
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mstatus_r  <= '0;
      mtvec_r    <= '0;
      mepc_r     <= '0;
      mcause_r   <= '0;
      mtval_r    <= '0;
      mscratch_r <= '0;
      satp_r     <= '0;
      priv_r     <= e_priv_m;
    end
    else if (exc_v)
    begin
      mepc_r   <= dword_width_c'(exc_pc_i);
      mcause_r <= dword_width_c'(cause);
      mtval_r  <= dword_width_c'(exc_tval_i);
      mstatus_r[mstatus_mpp_lsb_c +: 2] <= priv_r;
      priv_r   <= e_priv_m;
    end
    else if (mret_v)
    begin
      priv_r <= priv_e'(mstatus_r[mstatus_mpp_lsb_c +: 2]);
      mstatus_r[mstatus_mpp_lsb_c +: 2] <= e_priv_u;
    end
    else if (csr_we)
    begin
      case (cmd_i.addr)
        csr_mstatus_c:  mstatus_r  <= csr_wdata;
        csr_mtvec_c:    mtvec_r    <= csr_wdata;
        csr_mepc_c:     mepc_r     <= csr_wdata;
        csr_mcause_c:   mcause_r   <= csr_wdata;
        csr_mtval_c:    mtval_r    <= csr_wdata;
        csr_mscratch_c: mscratch_r <= csr_wdata;
        csr_satp_c:     satp_r     <= csr_wdata;
        default:        ;
      endcase
    end
  end

  assign data_o           = csr_rdata;
  assign priv_mode_o      = priv_r;
  assign satp_ppn_o       = satp_r[ptag_width_c-1:0];
  // machine mode always runs untranslated
  assign translation_en_o = satp_r[satp_mode_bit_c] & (priv_r != e_priv_m);
  assign mstatus_sum_o    = mstatus_r[mstatus_sum_bit_c];
  assign mstatus_mxr_o    = mstatus_r[mstatus_mxr_bit_c];

endmodule

// File: sys_pipe/sys_fault_sel.sv
`timescale 1ns/1ps

module sys_fault_sel
  import sys_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     is_store_i,
  input  sys_exc_s                 exc_i,
  input  logic [vaddr_width_c-1:0] exc_pc_i,
  input  logic [vaddr_width_c-1:0] exc_vaddr_i,
  input  ptw_fill_s                fill_i,
  input  logic                     kill_ex3_i,
  output ptw_miss_s                ptw_miss_o,
  output sys_exc_s                 exc_o,
  output logic [vaddr_width_c-1:0] exc_pc_o,
  output logic [vaddr_width_c-1:0] exc_tval_o
);

  logic is_store_ex2_r;
  logic is_store_ex3_r;
  logic fill_fault_v;

  // store flag follows the access down to stage three
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      is_store_ex2_r <= 1'b0;
      is_store_ex3_r <= 1'b0;
    end
    else
    begin
      is_store_ex2_r <= is_store_i;
      is_store_ex3_r <= is_store_ex2_r;
    end
  end

  assign fill_fault_v = fill_i.instr_page_fault_v
                      | fill_i.store_page_fault_v
                      | fill_i.load_page_fault_v;

  // walker faults win and ignore the ex3 kill
  always_comb
  begin
    exc_o = '0;
    if (fill_i.instr_page_fault_v)
      exc_o.instr_page_fault = 1'b1;
    else if (fill_i.store_page_fault_v)
      exc_o.store_page_fault = 1'b1;
    else if (fill_i.load_page_fault_v)
      exc_o.load_page_fault = 1'b1;
    else if (!kill_ex3_i)
      exc_o = exc_i;
  end

  assign exc_pc_o   = fill_fault_v ? fill_i.pc : exc_pc_i;
  assign exc_tval_o = fill_fault_v ? fill_i.vaddr : '0;

  // merged record is already killed
  always_comb
  begin
    ptw_miss_o.instr_miss_v = exc_o.itlb_miss;
    ptw_miss_o.load_miss_v  = exc_o.dtlb_miss & ~is_store_ex3_r;
    ptw_miss_o.store_miss_v = exc_o.dtlb_miss & is_store_ex3_r;
    ptw_miss_o.pc           = exc_pc_i;
    ptw_miss_o.vaddr        = exc_o.itlb_miss ? exc_pc_i : exc_vaddr_i;
  end

endmodule

// File: sys_pipe/sys_pipe.sv
`timescale 1ns/1ps

module sys_pipe
  import sys_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        op_v_i,
  input  sys_op_e                     op_i,
  input  logic [csr_addr_width_c-1:0] csr_addr_i,
  input  logic [dword_width_c-1:0]    rs1_i,
  input  logic [dword_width_c-1:0]    imm_i,
  input  logic                        is_store_i,
  input  logic                        kill_ex1_i,
  input  logic                        kill_ex2_i,
  input  logic                        kill_ex3_i,
  input  sys_exc_s                    exc_i,
  input  logic [vaddr_width_c-1:0]    exc_pc_i,
  input  logic [vaddr_width_c-1:0]    exc_vaddr_i,
  input  ptw_fill_s                   fill_i,
  output ptw_miss_s                   ptw_miss_o,
  output logic [dword_width_c-1:0]    data_o,
  output trap_pkt_s                   trap_o,
  output priv_e                       priv_mode_o,
  output logic [ptag_width_c-1:0]     satp_ppn_o,
  output logic                        translation_en_o,
  output logic                        mstatus_sum_o,
  output logic                        mstatus_mxr_o
);

  sys_cmd_s                 cmd;
  logic                     cmd_v;
  sys_exc_s                 exc_merged;
  logic [vaddr_width_c-1:0] exc_pc;
  logic [vaddr_width_c-1:0] exc_tval;

  sys_cmd_pipe cmd_pipe_i (
    .clk_i, .rst_n_i, .op_v_i, .op_i, .csr_addr_i, .rs1_i, .imm_i,
    .kill_ex1_i, .kill_ex2_i, .kill_ex3_i,
    .cmd_o(cmd), .cmd_v_o(cmd_v)
  );

  sys_fault_sel fault_sel_i (
    .clk_i, .rst_n_i, .is_store_i, .exc_i, .exc_pc_i, .exc_vaddr_i, .fill_i,
    .kill_ex3_i, .ptw_miss_o,
    .exc_o(exc_merged), .exc_pc_o(exc_pc), .exc_tval_o(exc_tval)
  );

  sys_csr_file csr_file_i (
    .clk_i, .rst_n_i, .cmd_i(cmd), .cmd_v_i(cmd_v), .exc_i(exc_merged),
    .exc_pc_i(exc_pc), .exc_tval_i(exc_tval), .data_o, .trap_o, .priv_mode_o,
    .satp_ppn_o, .translation_en_o, .mstatus_sum_o, .mstatus_mxr_o
  );

endmodule
